// ==== rtl/bus_arbiter.sv ====
`timescale 1ns/1ps

module bus_arbiter (
  input  logic              clk,
  input  logic              rst,
  input  bus_pkg::bus_req_t i_req_i,
  input  bus_pkg::bus_req_t d_req_i,
  output bus_pkg::bus_rsp_t i_rsp_o,
  output bus_pkg::bus_rsp_t d_rsp_o,
  output bus_pkg::ar_t      ar_o,
  input  logic              ar_ready_i,
  input  bus_pkg::r_t       r_i,
  output logic              r_ready_o,
  output bus_pkg::aw_t      aw_o,
  input  logic              aw_ready_i,
  output bus_pkg::w_t       w_o,
  input  logic              w_ready_i,
  input  bus_pkg::b_t       b_i,
  output logic              b_ready_o
);

  typedef enum logic [2:0] {
    st_idle,
    st_read_addr,
    st_read_data,
    st_write_req,
    st_write_resp
  } arb_state_e;

  arb_state_e        state_q;
  logic              grant_d_q;  // data side owns the bus
  logic              aw_pend_q;
  logic              w_pend_q;
  logic              i_rsp_valid_q;
  logic              d_rsp_valid_q;
  bus_pkg::data_t    rsp_data_q;
  logic              d_pick;
  logic              i_pick;
  logic              new_wen;
  bus_pkg::bus_req_t own_req;
  logic              r_fire;
  logic              b_fire;
  logic              aw_done;
  logic              w_done;

  // a side whose response pulses now still shows its old valid
  assign d_pick  = d_req_i.valid && !d_rsp_valid_q;
  assign i_pick  = i_req_i.valid && !i_rsp_valid_q && !d_pick;
  assign new_wen = d_pick ? d_req_i.wen : i_req_i.wen;

  // requesters hold their fields, so the channels read them directly
  assign own_req = grant_d_q ? d_req_i : i_req_i;

  assign r_fire  = (state_q == st_read_data) && r_i.valid;
  assign b_fire  = (state_q == st_write_resp) && b_i.valid;
  assign aw_done = !aw_pend_q || aw_ready_i;
  assign w_done  = !w_pend_q || w_ready_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q       <= st_idle;
      grant_d_q     <= 1'b0;
      aw_pend_q     <= 1'b0;
      w_pend_q      <= 1'b0;
      i_rsp_valid_q <= 1'b0;
      d_rsp_valid_q <= 1'b0;
    end else begin
      i_rsp_valid_q <= (r_fire || b_fire) && !grant_d_q;
      d_rsp_valid_q <= (r_fire || b_fire) && grant_d_q;
      case (state_q)
        st_idle: begin
          if (d_pick || i_pick) begin
            grant_d_q <= d_pick;
            if (new_wen) begin
              aw_pend_q <= 1'b1;  // aw and w go up together
              w_pend_q  <= 1'b1;
              state_q   <= st_write_req;
            end else begin
              state_q <= st_read_addr;
            end
          end
        end
        st_read_addr: if (ar_ready_i) state_q <= st_read_data;
        st_read_data: if (r_i.valid) state_q <= st_idle;
        st_write_req: begin
          if (aw_ready_i) aw_pend_q <= 1'b0;
          if (w_ready_i) w_pend_q <= 1'b0;
          if (aw_done && w_done) state_q <= st_write_resp;
        end
        st_write_resp: if (b_i.valid) state_q <= st_idle;
        default: state_q <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (r_fire) begin
      rsp_data_q <= r_i.data;
    end else if (b_fire) begin
      rsp_data_q <= '0;
    end
  end

  assign ar_o.valid = (state_q == st_read_addr);
  assign ar_o.addr  = own_req.addr;
  assign r_ready_o  = (state_q == st_read_data);

  assign aw_o.valid = aw_pend_q;
  assign aw_o.addr  = own_req.addr;
  assign w_o.valid  = w_pend_q;
  assign w_o.data   = own_req.data;
  assign w_o.strb   = own_req.strb;
  assign b_ready_o  = (state_q == st_write_resp);

  assign i_rsp_o.valid = i_rsp_valid_q;
  assign i_rsp_o.data  = rsp_data_q;
  assign d_rsp_o.valid = d_rsp_valid_q;
  assign d_rsp_o.data  = rsp_data_q;

  // holds only while the granted requester keeps its request steady
  assert property (@(posedge clk) disable iff (rst)
    ar_o.valid && !ar_ready_i |=> ar_o.valid && $stable(ar_o.addr));

endmodule

// ==== rtl/bus_pkg.sv ====
package bus_pkg;

  // bus widths
  typedef logic [63:0] addr_t;  // always 8 byte aligned on the bus
  typedef logic [63:0] data_t;  // one beat
  typedef logic [7:0]  strb_t;  // one bit per byte lane

  // axi read address channel, single beat
  typedef struct packed {
    logic  valid;
    addr_t addr;
  } ar_t;

  // axi read data channel
  typedef struct packed {
    logic  valid;
    data_t data;
  } r_t;

  // axi write address channel
  typedef struct packed {
    logic  valid;
    addr_t addr;
  } aw_t;

  // axi write data channel
  typedef struct packed {
    logic  valid;
    data_t data;
    strb_t strb;
  } w_t;

  // axi write response, code ignored
  typedef struct packed {
    logic valid;
  } b_t;

  // requester to arbiter, valid held until the response
  typedef struct packed {
    logic  valid;
    logic  wen;
    addr_t addr;
    data_t data;
    strb_t strb;
  } bus_req_t;

  // arbiter to requester, valid is a single pulse
  typedef struct packed {
    logic  valid;
    data_t data;
  } bus_rsp_t;

endpackage

// ==== rtl/core_pkg.sv ====
package core_pkg;

  // cpu side widths
  typedef logic [31:0] pc_t;    // instruction address
  typedef logic [31:0] inst_t;  // one instruction word
  typedef logic [63:0] xlen_t;  // register width

  // memory op code
  // bit 2 selects zero extension, bits 1:0 give the size
  // stores use the four signed codes
  typedef enum logic [2:0] {
    lb  = 3'b000,
    lh  = 3'b001,
    lw  = 3'b010,
    ld  = 3'b011,
    lbu = 3'b100,
    lhu = 3'b101,
    lwu = 3'b110
  } mem_op_e;

  // branch or trap target from the pipeline
  typedef struct packed {
    logic valid;
    pc_t  target;
  } redirect_t;

  // one load or store from the pipeline
  typedef struct packed {
    logic    valid;
    logic    wen;    // 1 for store
    mem_op_e op;
    xlen_t   addr;   // byte address
    xlen_t   wdata;  // store data, low aligned
  } ls_req_t;

  // first fetch after reset
  localparam pc_t RESET_PC_DEFAULT = 32'h8000_0000;

endpackage

// ==== rtl/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit #(
  parameter core_pkg::pc_t RESET_PC = core_pkg::RESET_PC_DEFAULT
) (
  input  logic                clk,
  input  logic                rst,
  input  core_pkg::redirect_t redirect_i,
  input  logic                inst_ready_i,
  input  bus_pkg::bus_rsp_t   i_rsp_i,
  output bus_pkg::bus_req_t   i_req_o,
  output core_pkg::inst_t     inst_o,
  output core_pkg::pc_t       inst_pc_o,
  output logic                inst_valid_o
);

  typedef enum logic [1:0] {
    st_req,   // issue cycle of a fetch
    st_wait,  // fetch in flight
    st_hold   // instruction shown to the pipeline
  } fetch_state_e;

  fetch_state_e    state_q;
  core_pkg::pc_t   pc_q;        // pc of the fetch in flight or held
  core_pkg::pc_t   redir_pc_q;  // target seen while a fetch was in flight
  logic            discard_q;   // response in flight is stale
  core_pkg::inst_t inst_q;
  core_pkg::pc_t   next_pc;
  logic            in_flight;
  logic            consumed;

  assign in_flight = (state_q != st_hold);
  assign consumed  = inst_valid_o && inst_ready_i;

  always_comb begin
    if (redirect_i.valid) begin
      next_pc = redirect_i.target;
    end else if (discard_q) begin
      next_pc = redir_pc_q;
    end else begin
      next_pc = pc_q + 32'd4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q   <= st_req;
      pc_q      <= RESET_PC;
      discard_q <= 1'b0;
    end else begin
      case (state_q)
        st_req, st_wait: begin
          if (i_rsp_i.valid) begin
            if (discard_q || redirect_i.valid) begin
              pc_q      <= next_pc;  // drop the beat, refetch at target
              discard_q <= 1'b0;
              state_q   <= st_req;
            end else begin
              state_q <= st_hold;
            end
          end else begin
            state_q <= st_wait;
            if (redirect_i.valid) discard_q <= 1'b1;
          end
        end
        st_hold: begin
          if (redirect_i.valid || consumed) begin
            pc_q    <= next_pc;
            state_q <= st_req;
          end
        end
        default: state_q <= st_req;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (in_flight && redirect_i.valid) redir_pc_q <= redirect_i.target;
    if (in_flight && i_rsp_i.valid) begin
      inst_q <= pc_q[2] ? i_rsp_i.data[63:32] : i_rsp_i.data[31:0];  // word pick
    end
  end

  assign i_req_o.valid = in_flight;
  assign i_req_o.wen   = 1'b0;
  assign i_req_o.addr  = {32'h0, pc_q[31:3], 3'b000};
  assign i_req_o.data  = '0;
  assign i_req_o.strb  = '0;

  assign inst_o       = inst_q;
  assign inst_pc_o    = pc_q;
  assign inst_valid_o = (state_q == st_hold);

  // targets come from jumps and traps, always word aligned
  assert property (@(posedge clk) disable iff (rst)
    redirect_i.valid |-> redirect_i.target[1:0] == 2'b00);

  // arbiter needs at least a grant cycle and a channel cycle
  assert property (@(posedge clk) disable iff (rst)
    state_q == st_req |-> !i_rsp_i.valid);

endmodule

// ==== rtl/load_store_unit.sv ====
`timescale 1ns/1ps

module load_store_unit (
  input  logic              clk,
  input  logic              rst,
  input  core_pkg::ls_req_t ls_req_i,
  input  bus_pkg::bus_rsp_t d_rsp_i,
  output bus_pkg::bus_req_t d_req_o,
  output logic              ls_busy_o,
  output logic              ls_done_o,
  output core_pkg::xlen_t   ls_rdata_o
);

  logic              busy_q;
  logic              done_q;
  logic              wen_q;
  core_pkg::mem_op_e op_q;
  core_pkg::xlen_t   addr_q;
  core_pkg::xlen_t   wdata_q;
  core_pkg::xlen_t   rdata_q;
  logic              accept;
  logic              rsp_fire;
  logic [5:0]        lane_shift;  // byte offset in bits
  bus_pkg::strb_t    size_mask;   // strobe before the lane shift
  core_pkg::xlen_t   load_bytes;
  core_pkg::xlen_t   load_ext;
  logic [2:0]        req_align;   // address bits that must be zero

  assign accept     = ls_req_i.valid && !busy_q;
  assign rsp_fire   = busy_q && d_rsp_i.valid;
  assign lane_shift = {addr_q[2:0], 3'b000};

  always_comb begin
    case (op_q[1:0])
      2'b00:   size_mask = 8'h01;
      2'b01:   size_mask = 8'h03;
      2'b10:   size_mask = 8'h0f;
      default: size_mask = 8'hff;
    endcase
  end

  // stores go out in their byte lanes
  assign d_req_o.valid = busy_q;
  assign d_req_o.wen   = wen_q;
  assign d_req_o.addr  = {addr_q[63:3], 3'b000};
  assign d_req_o.data  = wdata_q << lane_shift;
  assign d_req_o.strb  = wen_q ? (size_mask << addr_q[2:0]) : '0;

  // loads come back down to bit 0
  assign load_bytes = d_rsp_i.data >> lane_shift;

  always_comb begin
    case (op_q)
      core_pkg::lb:  load_ext = {{56{load_bytes[7]}}, load_bytes[7:0]};
      core_pkg::lh:  load_ext = {{48{load_bytes[15]}}, load_bytes[15:0]};
      core_pkg::lw:  load_ext = {{32{load_bytes[31]}}, load_bytes[31:0]};
      core_pkg::lbu: load_ext = {56'h0, load_bytes[7:0]};
      core_pkg::lhu: load_ext = {48'h0, load_bytes[15:0]};
      core_pkg::lwu: load_ext = {32'h0, load_bytes[31:0]};
      default:       load_ext = load_bytes;  // ld
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
    end else begin
      done_q <= rsp_fire;
      if (accept) begin
        busy_q <= 1'b1;
      end else if (rsp_fire) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      wen_q   <= ls_req_i.wen;
      op_q    <= ls_req_i.op;
      addr_q  <= ls_req_i.addr;
      wdata_q <= ls_req_i.wdata;
    end
    if (rsp_fire) rdata_q <= load_ext;  // zero for a store
  end

  assign ls_busy_o  = busy_q;
  assign ls_done_o  = done_q;
  assign ls_rdata_o = rdata_q;

  always_comb begin
    case (ls_req_i.op[1:0])
      2'b00:   req_align = 3'b000;
      2'b01:   req_align = 3'b001;
      2'b10:   req_align = 3'b011;
      default: req_align = 3'b111;
    endcase
  end

  // naturally aligned accesses never cross a beat
  assert property (@(posedge clk) disable iff (rst)
    accept |-> (ls_req_i.addr[2:0] & req_align) == 3'b000);

  // pipeline must wait for busy to drop
  assert property (@(posedge clk) disable iff (rst)
    ls_busy_o |-> !ls_req_i.valid);

endmodule

// ==== rtl/mem_frontend_top.sv ====
`timescale 1ns/1ps

module mem_frontend_top #(
  parameter core_pkg::pc_t RESET_PC = core_pkg::RESET_PC_DEFAULT
) (
  input  logic                clk,
  input  logic                rst,
  // fetch side
  input  core_pkg::redirect_t redirect_i,
  input  logic                inst_ready_i,
  output core_pkg::inst_t     inst_o,
  output core_pkg::pc_t       inst_pc_o,
  output logic                inst_valid_o,
  // load/store side
  input  core_pkg::ls_req_t   ls_req_i,
  output logic                ls_busy_o,
  output logic                ls_done_o,
  output core_pkg::xlen_t     ls_rdata_o,
  // axi master
  output bus_pkg::ar_t        ar_o,
  input  logic                ar_ready_i,
  input  bus_pkg::r_t         r_i,
  output logic                r_ready_o,
  output bus_pkg::aw_t        aw_o,
  input  logic                aw_ready_i,
  output bus_pkg::w_t         w_o,
  input  logic                w_ready_i,
  input  bus_pkg::b_t         b_i,
  output logic                b_ready_o
);

  bus_pkg::bus_req_t i_req;
  bus_pkg::bus_req_t d_req;
  bus_pkg::bus_rsp_t i_rsp;
  bus_pkg::bus_rsp_t d_rsp;

  fetch_unit #(
    .RESET_PC (RESET_PC)
  ) u_fetch (
    .clk          (clk),
    .rst          (rst),
    .redirect_i   (redirect_i),
    .inst_ready_i (inst_ready_i),
    .i_rsp_i      (i_rsp),
    .i_req_o      (i_req),
    .inst_o       (inst_o),
    .inst_pc_o    (inst_pc_o),
    .inst_valid_o (inst_valid_o)
  );

  load_store_unit u_lsu (
    .clk        (clk),
    .rst        (rst),
    .ls_req_i   (ls_req_i),
    .d_rsp_i    (d_rsp),
    .d_req_o    (d_req),
    .ls_busy_o  (ls_busy_o),
    .ls_done_o  (ls_done_o),
    .ls_rdata_o (ls_rdata_o)
  );

  // data before instructions
  bus_arbiter u_arb (
    .clk        (clk),
    .rst        (rst),
    .i_req_i    (i_req),
    .d_req_i    (d_req),
    .i_rsp_o    (i_rsp),
    .d_rsp_o    (d_rsp),
    .ar_o       (ar_o),
    .ar_ready_i (ar_ready_i),
    .r_i        (r_i),
    .r_ready_o  (r_ready_o),
    .aw_o       (aw_o),
    .aw_ready_i (aw_ready_i),
    .w_o        (w_o),
    .w_ready_i  (w_ready_i),
    .b_i        (b_i),
    .b_ready_o  (b_ready_o)
  );

endmodule

// ==== run.sh ====
#!/bin/sh
# build with verilator, run, then judge the run from its log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module tb_top -f verilog.f -o tb_top_sim \
  || { echo "verilator build failed"; exit 1; }
./obj_dir/tb_top_sim > sim.log 2>&1 ; cat sim.log
grep -q "=== FAIL ===" sim.log && { echo "simulation failed"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "simulation ended without passing"; exit 1; }
exit 0

// ==== test/tb_tests.svh ====
core_pkg::pc_t exp_pc;  // pc of the next instruction the pipeline should see

task automatic wait_inst_valid();
  int n;
  n = 0;
  while (!inst_valid) begin
    @(negedge clk);
    n++;
    if (n > WAIT_LIMIT) abort_run("timeout waiting for an instruction");
  end
endtask

task automatic wait_ls_idle();
  int n;
  n = 0;
  while (ls_busy) begin
    @(negedge clk);
    n++;
    if (n > WAIT_LIMIT) abort_run("timeout waiting for the load/store unit to go idle");
  end
endtask

task automatic wait_ls_done();
  int n;
  n = 0;
  while (!ls_done) begin
    @(negedge clk);
    n++;
    if (n > WAIT_LIMIT) abort_run("timeout waiting for a load/store to finish");
  end
endtask

// sign or zero extension from the op code alone
function automatic core_pkg::xlen_t extend_load(core_pkg::mem_op_e op, core_pkg::xlen_t v);
  int nbits;
  core_pkg::xlen_t mask;
  nbits = 8 << op[1:0];
  mask = (nbits == 64) ? '1 : ((64'd1 << nbits) - 64'd1);
  if (!op[2] && v[nbits-1]) return v | ~mask;
  return v & mask;
endfunction

function automatic core_pkg::xlen_t lane_mask(bus_pkg::strb_t s);
  core_pkg::xlen_t m;
  for (int i = 0; i < 8; i++) m[8*i +: 8] = {8{s[i]}};
  return m;
endfunction

task automatic take_inst(output core_pkg::pc_t pc, output core_pkg::inst_t word);
  wait_inst_valid();
  pc         = inst_pc;
  word       = inst;
  inst_ready = 1'b1;
  @(negedge clk);
  inst_ready = 1'b0;
endtask

task automatic expect_next_inst();
  core_pkg::pc_t   pc;
  core_pkg::inst_t word;
  bus_pkg::data_t  beat;
  take_inst(pc, word);
  beat = read_mem({32'h0, exp_pc[31:3], 3'b000});
  check_pc("inst_pc_o", pc, exp_pc);
  check_inst("inst_o", word, exp_pc[2] ? beat[63:32] : beat[31:0]);  // word by pc bit 2
  exp_pc = exp_pc + 32'd4;
endtask

task automatic redirect_to(core_pkg::pc_t target);
  redirect = '{valid: 1'b1, target: target};
  @(negedge clk);
  redirect.valid = 1'b0;
  exp_pc = target;
endtask

task automatic ls_access(logic wen, core_pkg::mem_op_e op, core_pkg::xlen_t addr,
                         core_pkg::xlen_t wdata, output core_pkg::xlen_t rdata);
  wait_ls_idle();
  ls_req = '{valid: 1'b1, wen: wen, op: op, addr: addr, wdata: wdata};
  @(negedge clk);
  ls_req.valid = 1'b0;
  wait_ls_done();
  rdata = ls_rdata;
endtask

task automatic test_sequential();
  exp_pc = RESET_PC;
  repeat (8) expect_next_inst();
endtask

task automatic test_redirect();
  wait_inst_valid();
  redirect_to(32'h8000_0a04);  // drops the held instruction
  repeat (3) expect_next_inst();
  expect_next_inst();
  redirect_to(32'h8000_2000);  // hits the fetch just issued
  repeat (3) expect_next_inst();
endtask

task automatic test_store_load();
  core_pkg::mem_op_e op;
  core_pkg::xlen_t   addr;
  core_pkg::xlen_t   wdata;
  core_pkg::xlen_t   rdata;
  core_pkg::xlen_t   lanes;
  bus_pkg::strb_t    strb;
  for (int size = 0; size < 4; size++) begin
    for (int off = 0; off < 8; off += (1 << size)) begin
      op   = core_pkg::mem_op_e'(3'(size));
      addr = 64'h8000_4000 + 64'(size * 8 + off);
      rand_data(wdata);
      ls_access(1'b1, op, addr, wdata, rdata);
      strb  = 8'(((1 << (1 << size)) - 1) << off);
      lanes = lane_mask(strb);
      check_xlen("aw_o.addr", wr_addr, addr & ~64'h7);
      check_strb("w_o.strb", wr_strb, strb);
      check_xlen("w_o.data", wr_data & lanes, (wdata << (8 * off)) & lanes);
      ls_access(1'b0, op, addr, '0, rdata);
      check_xlen("ls_rdata_o", rdata, extend_load(op, wdata));
      if (size < 3) begin
        op = core_pkg::mem_op_e'(3'(size + 4));  // unsigned form
        ls_access(1'b0, op, addr, '0, rdata);
        check_xlen("ls_rdata_o", rdata, extend_load(op, wdata));
      end
    end
  end
endtask

task automatic test_concurrent();
  core_pkg::xlen_t rdata;
  bus_pkg::data_t  beat;
  beat = read_mem(64'h8000_6000);
  fork
    ls_access(1'b0, core_pkg::lw, 64'h8000_6004, '0, rdata);
    repeat (4) expect_next_inst();
  join
  check_xlen("ls_rdata_o", rdata, extend_load(core_pkg::lw, beat >> 32));
endtask

task automatic test_back_pressure();
  core_pkg::pc_t   held_pc;
  core_pkg::inst_t held_inst;
  wait_inst_valid();
  held_pc   = inst_pc;
  held_inst = inst;
  repeat (40) begin
    @(negedge clk);
    if (!inst_valid) abort_run("held instruction was dropped");
    if (ar.valid) abort_run("read address issued while an instruction was held");
    check_pc("inst_pc_o", inst_pc, held_pc);
    check_inst("inst_o", inst, held_inst);
  end
  repeat (4) expect_next_inst();
endtask

task automatic run_all_tests();
  test_sequential();
  test_redirect();
  test_store_load();
  test_concurrent();
  test_back_pressure();
endtask

// ==== test/tb_top.sv ====
`timescale 1ns/1ps

module tb_top;

  localparam core_pkg::pc_t RESET_PC = core_pkg::RESET_PC_DEFAULT;
  localparam int WAIT_LIMIT = 200;  // cycles allowed per wait

  logic                clk;
  logic                rst;
  core_pkg::redirect_t redirect;
  logic                inst_ready;
  core_pkg::inst_t     inst;
  core_pkg::pc_t       inst_pc;
  logic                inst_valid;
  core_pkg::ls_req_t   ls_req;
  logic                ls_busy;
  logic                ls_done;
  core_pkg::xlen_t     ls_rdata;
  bus_pkg::ar_t        ar;
  logic                ar_ready = 1'b0;
  bus_pkg::r_t         r = '0;
  logic                r_ready;
  bus_pkg::aw_t        aw;
  logic                aw_ready = 1'b0;
  bus_pkg::w_t         w;
  logic                w_ready = 1'b0;
  bus_pkg::b_t         b = '0;
  logic                b_ready;

  // axi slave model state
  bus_pkg::data_t mem [bus_pkg::addr_t];
  logic [31:0]    slave_lfsr = 32'ha9c9;  // ready delays
  logic [31:0]    data_lfsr = 32'ha9c9;   // store data
  logic           ar_hs = 1'b0;           // handshake due at the next rising edge
  logic           r_hs = 1'b0;
  logic           aw_hs = 1'b0;
  logic           w_hs = 1'b0;
  logic           b_hs = 1'b0;
  logic           rd_busy = 1'b0;
  logic           aw_got = 1'b0;
  logic           w_got = 1'b0;
  logic           b_pend = 1'b0;
  int             ar_wait = 0;
  int             r_wait = 0;
  int             aw_wait = 0;
  int             w_wait = 0;
  int             b_wait = 0;
  bus_pkg::addr_t rd_addr;
  bus_pkg::addr_t wr_addr;
  bus_pkg::data_t wr_data;  // last accepted w beat
  bus_pkg::strb_t wr_strb;

  mem_frontend_top #(
    .RESET_PC (RESET_PC)
  ) uut (
    .clk          (clk),
    .rst          (rst),
    .redirect_i   (redirect),
    .inst_ready_i (inst_ready),
    .inst_o       (inst),
    .inst_pc_o    (inst_pc),
    .inst_valid_o (inst_valid),
    .ls_req_i     (ls_req),
    .ls_busy_o    (ls_busy),
    .ls_done_o    (ls_done),
    .ls_rdata_o   (ls_rdata),
    .ar_o         (ar),
    .ar_ready_i   (ar_ready),
    .r_i          (r),
    .r_ready_o    (r_ready),
    .aw_o         (aw),
    .aw_ready_i   (aw_ready),
    .w_o          (w),
    .w_ready_i    (w_ready),
    .b_i          (b),
    .b_ready_o    (b_ready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_delay(output int d);
    d = 0;
    repeat (2) begin
      slave_lfsr = lfsr_next(slave_lfsr);
      d = (d << 1) | int'(slave_lfsr[0]);
    end
  endtask

  task automatic rand_data(output core_pkg::xlen_t v);
    repeat (64) begin
      data_lfsr = lfsr_next(data_lfsr);
      v = {v[62:0], data_lfsr[0]};
    end
  endtask

  task automatic tick_delay(inout int cnt, output logic done);
    done = (cnt == 0);
    if (done) rand_delay(cnt);  // reload for the next transfer
    else cnt--;
  endtask

  // unwritten beats read back a pattern of the full address
  function automatic bus_pkg::data_t read_mem(bus_pkg::addr_t a);
    if (mem.exists(a)) return mem[a];
    return {~a[31:0] ^ a[63:32], a[31:0] ^ a[63:32] ^ 32'h0bad_f00d};
  endfunction

  task automatic write_beat(bus_pkg::addr_t a, bus_pkg::data_t d, bus_pkg::strb_t s);
    bus_pkg::data_t line;
    line = read_mem(a);
    for (int i = 0; i < 8; i++) begin
      if (s[i]) line[8*i +: 8] = d[8*i +: 8];
    end
    mem[a] = line;
  endtask

  task automatic abort_run(string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_pc(string name, core_pkg::pc_t got, core_pkg::pc_t exp);
    if (got !== exp) abort_run($sformatf("MISMATCH %s: got %h, expected %h", name, got, exp));
  endtask

  task automatic check_inst(string name, core_pkg::inst_t got, core_pkg::inst_t exp);
    if (got !== exp) abort_run($sformatf("MISMATCH %s: got %h, expected %h", name, got, exp));
  endtask

  task automatic check_xlen(string name, core_pkg::xlen_t got, core_pkg::xlen_t exp);
    if (got !== exp) abort_run($sformatf("MISMATCH %s: got %h, expected %h", name, got, exp));
  endtask

  task automatic check_strb(string name, bus_pkg::strb_t got, bus_pkg::strb_t exp);
    if (got !== exp) abort_run($sformatf("MISMATCH %s: got %h, expected %h", name, got, exp));
  endtask

  // slave outputs change on the falling edge only
  always @(negedge clk) begin : slave_model
    logic go;
    if (!rst) begin
      // transfers agreed on one falling edge ago are done now
      if (ar_hs) begin
        ar_ready = 1'b0;
        rd_busy  = 1'b1;
      end
      if (r_hs) begin
        r       = '0;
        rd_busy = 1'b0;
      end
      if (aw_hs) begin
        aw_ready = 1'b0;
        aw_got   = 1'b1;
      end
      if (w_hs) begin
        w_ready = 1'b0;
        w_got   = 1'b1;
      end
      if (b_hs) b = '0;
      if (aw_got && w_got) begin
        write_beat(wr_addr, wr_data, wr_strb);
        aw_got = 1'b0;
        w_got  = 1'b0;
        b_pend = 1'b1;
      end
      if (ar.valid && !ar_ready && !rd_busy) begin
        tick_delay(ar_wait, go);
        ar_ready = go;
      end
      if (rd_busy && !r.valid) begin
        tick_delay(r_wait, go);
        if (go) r = '{valid: 1'b1, data: read_mem(rd_addr)};
      end
      if (aw.valid && !aw_ready) begin
        tick_delay(aw_wait, go);
        aw_ready = go;
      end
      if (w.valid && !w_ready) begin
        tick_delay(w_wait, go);
        w_ready = go;
      end
      if (b_pend && !b.valid) begin
        tick_delay(b_wait, go);
        b.valid = go;
        b_pend  = !go;
      end
      ar_hs = ar.valid && ar_ready;
      r_hs  = r.valid && r_ready;
      aw_hs = aw.valid && aw_ready;
      w_hs  = w.valid && w_ready;
      b_hs  = b.valid && b_ready;
      if (ar_hs) rd_addr = ar.addr;
      if (aw_hs) wr_addr = aw.addr;
      if (w_hs) begin
        wr_data = w.data;
        wr_strb = w.strb;
      end
    end
  end

  `include "tb_tests.svh"

  initial begin
    rst        = 1'b1;
    redirect   = '0;
    inst_ready = 1'b0;
    ls_req     = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    run_all_tests();
    $display("=== PASS ===");
    $finish;
  end

  initial begin
    #100000;
    abort_run("simulation time limit reached");
  end

endmodule

// ==== verilog.f ====
+incdir+test
rtl/core_pkg.sv
rtl/bus_pkg.sv
rtl/fetch_unit.sv
rtl/load_store_unit.sv
rtl/bus_arbiter.sv
rtl/mem_frontend_top.sv
test/tb_top.sv
